// ==== compile.f ====
+incdir+.
sysctl_map_pkg.sv
sysctl_sram_pkg.sv
sysctl_target_if.sv
sysctl_decoder.sv
sysctl_bram.sv
sysctl_sram_ctrl.sv
sysctl_io_regs.sv
sysctl_top.sv
sysctl_sva.sv
tb_sysctl.sv

// ==== sysctl_bram.sv ====
// On-chip 8 KiB block RAM target. Answers one cycle after sel, writes
// only the strobed byte lanes and reads the word held before the write.
`include "sysctl_defines.svh"

module sysctl_bram (
	input  logic clk,
	sysctl_target_if.target bus_i
);

	logic [`SYSCTL_DATA_W-1:0] mem [0:`SYSCTL_BRAM_WORDS-1];
	logic [`SYSCTL_BRAM_AW-1:0] word;
	logic access;

	assign word = bus_i.addr[`SYSCTL_BRAM_AW+1:2];
	// Only the first cycle of a select counts
	assign access = bus_i.sel && !bus_i.ready;

	always_ff @(posedge clk) begin
		bus_i.ready <= access;
	end

	always_ff @(posedge clk) begin
		if (access) begin
			for (int i = 0; i < `SYSCTL_STRB_W; i++) begin
				if (bus_i.wstrb[i])
					mem[word][i*8 +: 8] <= bus_i.wdata[i*8 +: 8];
			end
			bus_i.rdata <= mem[word];
		end
	end

endmodule

// ==== sysctl_decoder.sv ====
// CPU bus front end. Classifies each request by address region, runs the
// selected target until it is ready and returns its data with mem_ready_o.
`include "sysctl_defines.svh"

module sysctl_decoder (
	input  logic clk,
	input  logic resetn,
	input  logic mem_valid_i,
	input  logic [`SYSCTL_ADDR_W-1:0] mem_addr_i,
	input  logic [`SYSCTL_DATA_W-1:0] mem_wdata_i,
	input  logic [`SYSCTL_STRB_W-1:0] mem_wstrb_i,
	output logic mem_ready_o,
	output logic [`SYSCTL_DATA_W-1:0] mem_rdata_o,
	sysctl_target_if.host bram_o,
	sysctl_target_if.host sram_o,
	sysctl_target_if.host io_o
);

	sysctl_map_pkg::region_e region, region_q;
	logic [`SYSCTL_ADDR_W-1:0] offset_full;
	logic [`SYSCTL_OFFSET_W-1:0] addr_q;
	logic [`SYSCTL_DATA_W-1:0] wdata_q;
	logic [`SYSCTL_STRB_W-1:0] wstrb_q;
	logic busy_q, wait_q;
	logic accept;
	logic tgt_ready;
	logic [`SYSCTL_DATA_W-1:0] tgt_rdata;

	assign offset_full = mem_addr_i & `SYSCTL_OFFSET_MASK;
	assign accept = mem_valid_i && !busy_q && !wait_q;

	always_comb begin
		if (mem_addr_i < `SYSCTL_BRAM_WORDS * 4)
			region = sysctl_map_pkg::REGION_BRAM;
		else if ((mem_addr_i & `SYSCTL_REGION_MASK) == `SYSCTL_SRAM_BASE)
			region = sysctl_map_pkg::REGION_SRAM;
		else if ((mem_addr_i & `SYSCTL_REGION_MASK) == `SYSCTL_IO_BASE)
			region = sysctl_map_pkg::REGION_IO;
		else
			region = sysctl_map_pkg::REGION_NONE;
	end

	// Reply of the target that owns the request in flight
	always_comb begin
		case (region_q)
			sysctl_map_pkg::REGION_BRAM: {tgt_ready, tgt_rdata} = {bram_o.ready, bram_o.rdata};
			sysctl_map_pkg::REGION_SRAM: {tgt_ready, tgt_rdata} = {sram_o.ready, sram_o.rdata};
			sysctl_map_pkg::REGION_IO: {tgt_ready, tgt_rdata} = {io_o.ready, io_o.rdata};
			default: {tgt_ready, tgt_rdata} = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			region_q <= sysctl_map_pkg::REGION_NONE;
			busy_q <= 1'b0;
			wait_q <= 1'b0;
			mem_ready_o <= 1'b0;
			bram_o.sel <= 1'b0;
			sram_o.sel <= 1'b0;
			io_o.sel <= 1'b0;
		end else begin
			mem_ready_o <= 1'b0;
			if (accept) begin
				region_q <= region;
				if (region == sysctl_map_pkg::REGION_NONE) begin
					// Nothing mapped here, answer at once
					mem_ready_o <= 1'b1;
					wait_q <= 1'b1;
				end else begin
					busy_q <= 1'b1;
					bram_o.sel <= (region == sysctl_map_pkg::REGION_BRAM);
					sram_o.sel <= (region == sysctl_map_pkg::REGION_SRAM);
					io_o.sel <= (region == sysctl_map_pkg::REGION_IO);
				end
			end else if (busy_q && tgt_ready) begin
				busy_q <= 1'b0;
				wait_q <= 1'b1;
				mem_ready_o <= 1'b1;
				bram_o.sel <= 1'b0;
				sram_o.sel <= 1'b0;
				io_o.sel <= 1'b0;
			end else if (wait_q && !mem_valid_i) begin
				wait_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= offset_full[`SYSCTL_OFFSET_W-1:0];
			wdata_q <= mem_wdata_i;
			wstrb_q <= mem_wstrb_i;
			if (region == sysctl_map_pkg::REGION_NONE)
				mem_rdata_o <= '0;
		end else if (busy_q && tgt_ready) begin
			mem_rdata_o <= tgt_rdata;
		end
	end

	assign bram_o.addr = addr_q;
	assign bram_o.wdata = wdata_q;
	assign bram_o.wstrb = wstrb_q;
	assign sram_o.addr = addr_q;
	assign sram_o.wdata = wdata_q;
	assign sram_o.wstrb = wstrb_q;
	assign io_o.addr = addr_q;
	assign io_o.wdata = wdata_q;
	assign io_o.wstrb = wstrb_q;

endmodule

// ==== sysctl_defines.svh ====
// Address map, bus widths and sizes of the system controller.
// Include this header in any file that needs a width or a region base.
`ifndef SYSCTL_DEFINES_SVH
`define SYSCTL_DEFINES_SVH

// CPU bus
`define SYSCTL_ADDR_W 32
`define SYSCTL_DATA_W 32
`define SYSCTL_STRB_W 4

// Region decode
`define SYSCTL_REGION_MASK 32'hF000_0000
`define SYSCTL_OFFSET_MASK 32'h0FFF_FFFF
`define SYSCTL_OFFSET_W 28
`define SYSCTL_SRAM_BASE 32'h2000_0000
`define SYSCTL_IO_BASE 32'hF000_0000

// Block RAM, 8 KiB at address zero
`define SYSCTL_BRAM_WORDS 2048
`define SYSCTL_BRAM_AW 11

// External halfword SRAM
`define SYSCTL_SRAM_AW 18
`define SYSCTL_SRAM_DW 16

`define SYSCTL_TICKS_PER_SEC 50000000

`endif

// ==== sysctl_io_regs.sv ====
// I/O register page: LED, seconds counter and SD-card bit-bang pins.
// Registers are picked by the low 16 offset bits, ready one cycle after sel.
`include "sysctl_defines.svh"

module sysctl_io_regs #(
	parameter int TICKS_PER_SEC = `SYSCTL_TICKS_PER_SEC
) (
	input  logic clk,
	input  logic resetn,
	sysctl_target_if.target bus_i,
	output logic led_o,
	output logic sd_ss_o,
	output logic sd_sck_o,
	output logic sd_mosi_o,
	input  logic sd_miso_i
);

	localparam int PRE_W = $clog2(TICKS_PER_SEC + 1);

	sysctl_map_pkg::io_reg_e reg_sel;
	logic [PRE_W-1:0] prescale_q;
	logic [`SYSCTL_DATA_W-1:0] secs_q;
	logic [`SYSCTL_DATA_W-1:0] rd_word;
	logic access, is_write;

	assign reg_sel = sysctl_map_pkg::io_reg_e'(bus_i.addr[15:0]);
	assign access = bus_i.sel && !bus_i.ready;
	assign is_write = |bus_i.wstrb;

	// Seconds tick from a clk prescaler
	always_ff @(posedge clk) begin
		if (!resetn) begin
			prescale_q <= '0;
			secs_q <= '0;
		end else if (prescale_q == PRE_W'(TICKS_PER_SEC - 1)) begin
			prescale_q <= '0;
			secs_q <= secs_q + 1'b1;
		end else begin
			prescale_q <= prescale_q + 1'b1;
		end
	end

	always_comb begin
		rd_word = '0;
		case (reg_sel)
			sysctl_map_pkg::IO_LED: rd_word[0] = ~led_o;
			sysctl_map_pkg::IO_SECS: rd_word = secs_q;
			sysctl_map_pkg::IO_SD: rd_word[3:0] = {sd_ss_o, sd_sck_o, sd_mosi_o, sd_miso_i};
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			bus_i.ready <= 1'b0;
			led_o <= 1'b1;
			sd_ss_o <= 1'b1;
			sd_sck_o <= 1'b0;
			sd_mosi_o <= 1'b0;
		end else begin
			bus_i.ready <= access;
			if (access && is_write) begin
				case (reg_sel)
					// LED pin is active low
					sysctl_map_pkg::IO_LED: led_o <= ~bus_i.wdata[0];
					sysctl_map_pkg::IO_SD: {sd_ss_o, sd_sck_o, sd_mosi_o} <= bus_i.wdata[3:1];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access)
			bus_i.rdata <= rd_word;
	end

endmodule

// ==== sysctl_map_pkg.sv ====
// Types describing the memory map: the decoded address region and
// the register offsets inside the I/O page.
package sysctl_map_pkg;

	// Region selected by the top address nibble
	typedef enum logic [1:0] {
		REGION_BRAM,
		REGION_SRAM,
		REGION_IO,
		REGION_NONE
	} region_e;

	// Low 16 bits of an I/O page offset
	typedef enum logic [15:0] {
		IO_LED  = 16'h1000,
		IO_SECS = 16'h1100,
		IO_SD   = 16'h2000
	} io_reg_e;

endpackage

// ==== sysctl_sram_ctrl.sv ====
// Controller for the 16-bit asynchronous SRAM. A 32-bit write becomes two
// halfword write cycles, a 32-bit read two halfword reads with ready on
// the third cycle. The halfword address is the word offset plus a lane bit.
`include "sysctl_defines.svh"

module sysctl_sram_ctrl (
	input  logic clk,
	input  logic resetn,
	sysctl_target_if.target bus_i,
	output logic [`SYSCTL_SRAM_AW-1:0] sram_addr_o,
	output logic [`SYSCTL_SRAM_DW-1:0] sram_data_o,
	input  logic [`SYSCTL_SRAM_DW-1:0] sram_data_i,
	output logic sram_data_oe_o,
	output logic sram_we_n_o,
	output logic sram_oe_n_o,
	output logic sram_lb_n_o,
	output logic sram_ub_n_o
);

	sysctl_sram_pkg::sram_step_e step_q;
	logic [`SYSCTL_SRAM_AW-2:0] word_off;
	logic is_write;

	assign word_off = bus_i.addr[`SYSCTL_SRAM_AW:2];
	assign is_write = |bus_i.wstrb;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			step_q <= sysctl_sram_pkg::SRAM_IDLE;
			bus_i.ready <= 1'b0;
			sram_data_oe_o <= 1'b0;
			sram_we_n_o <= 1'b1;
			sram_oe_n_o <= 1'b1;
			sram_lb_n_o <= 1'b1;
			sram_ub_n_o <= 1'b1;
		end else begin
			// Pins go idle unless a step below keeps them active
			bus_i.ready <= 1'b0;
			sram_data_oe_o <= 1'b0;
			sram_we_n_o <= 1'b1;
			sram_oe_n_o <= 1'b1;
			sram_lb_n_o <= 1'b1;
			sram_ub_n_o <= 1'b1;
			case (step_q)
				sysctl_sram_pkg::SRAM_IDLE: begin
					if (bus_i.sel && !bus_i.ready) begin
						sram_addr_o <= {word_off, sysctl_sram_pkg::LANE_LOW};
						if (is_write) begin
							sram_data_o <= bus_i.wdata[`SYSCTL_SRAM_DW-1:0];
							sram_data_oe_o <= 1'b1;
							sram_we_n_o <= !(|bus_i.wstrb[1:0]);
							sram_lb_n_o <= !bus_i.wstrb[0];
							sram_ub_n_o <= !bus_i.wstrb[1];
						end else begin
							sram_oe_n_o <= 1'b0;
							sram_lb_n_o <= 1'b0;
							sram_ub_n_o <= 1'b0;
						end
						step_q <= sysctl_sram_pkg::SRAM_LOW;
					end
				end
				sysctl_sram_pkg::SRAM_LOW: begin
					sram_addr_o <= {word_off, sysctl_sram_pkg::LANE_HIGH};
					if (is_write) begin
						sram_data_o <= bus_i.wdata[`SYSCTL_DATA_W-1:`SYSCTL_SRAM_DW];
						sram_data_oe_o <= 1'b1;
						sram_we_n_o <= !(|bus_i.wstrb[3:2]);
						sram_lb_n_o <= !bus_i.wstrb[2];
						sram_ub_n_o <= !bus_i.wstrb[3];
						bus_i.ready <= 1'b1;
						step_q <= sysctl_sram_pkg::SRAM_IDLE;
					end else begin
						bus_i.rdata[`SYSCTL_SRAM_DW-1:0] <= sram_data_i;
						sram_oe_n_o <= 1'b0;
						sram_lb_n_o <= 1'b0;
						sram_ub_n_o <= 1'b0;
						step_q <= sysctl_sram_pkg::SRAM_HIGH;
					end
				end
				sysctl_sram_pkg::SRAM_HIGH: begin
					// Upper halfword has settled on the high address
					bus_i.rdata[`SYSCTL_DATA_W-1:`SYSCTL_SRAM_DW] <= sram_data_i;
					bus_i.ready <= 1'b1;
					step_q <= sysctl_sram_pkg::SRAM_IDLE;
				end
				default: step_q <= sysctl_sram_pkg::SRAM_IDLE;
			endcase
		end
	end

endmodule

// ==== sysctl_sram_pkg.sv ====
// Types for the external SRAM sequencer: its steps and the halfword
// lane that forms the lowest SRAM address bit.
package sysctl_sram_pkg;

	typedef enum logic [1:0] {
		SRAM_IDLE,
		SRAM_LOW,
		SRAM_HIGH
	} sram_step_e;

	typedef enum logic [0:0] {
		LANE_LOW  = 1'b0,
		LANE_HIGH = 1'b1
	} sram_lane_e;

endpackage

// ==== sysctl_sva.sv ====
// Concurrent checks on the system controller top level, attached by bind.
// Covers the ready pulse, SRAM write enables and the state held in reset.
module sysctl_sva (
	input logic clk,
	input logic resetn,
	input logic mem_valid_i,
	input logic mem_ready_o,
	input logic sram_data_oe_o,
	input logic sram_we_n_o,
	input logic sram_lb_n_o,
	input logic sram_ub_n_o,
	input logic led_o,
	input logic sd_ss_o,
	input logic sd_sck_o,
	input logic sd_mosi_o
);
	timeunit 1ns;
	timeprecision 1ps;

	ready_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
		mem_ready_o |=> !mem_ready_o)
		else $error("mem_ready_o stayed high for two cycles");

	ready_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
		$rose(mem_ready_o) |-> $past(mem_valid_i))
		else $error("mem_ready_o rose without a pending request");

	// Write strobe only while the data bus is driven
	write_drives_data: assert property (@(posedge clk) disable iff (!resetn)
		!sram_we_n_o |-> sram_data_oe_o)
		else $error("sram_we_n_o low with sram_data_oe_o low");

	reset_state: assert property (@(posedge clk)
		(!resetn ##1 !resetn) |-> (!mem_ready_o && !sram_data_oe_o && sram_we_n_o &&
			sram_lb_n_o && sram_ub_n_o && led_o && sd_ss_o && !sd_sck_o && !sd_mosi_o))
		else $error("Outputs not idle while resetn is low");

endmodule

bind sysctl_top sysctl_sva u_sva (.*);

// ==== sysctl_target_if.sv ====
// Link between the bus decoder and one memory or register target.
// sel is held from issue until the target answers with a one-cycle ready.
`include "sysctl_defines.svh"

interface sysctl_target_if;

	logic sel;
	logic [`SYSCTL_OFFSET_W-1:0] addr;
	logic [`SYSCTL_DATA_W-1:0] wdata;
	logic [`SYSCTL_STRB_W-1:0] wstrb;
	logic ready;
	logic [`SYSCTL_DATA_W-1:0] rdata;

	modport host (
		output sel, addr, wdata, wstrb,
		input ready, rdata
	);

	modport target (
		input sel, addr, wdata, wstrb,
		output ready, rdata
	);

endinterface

// ==== sysctl_top.sv ====
// Top level of the system controller memory-bus core.
// The CPU bus arrives on plain ports and fans out through the decoder
// to block RAM, the external SRAM controller and the I/O page.
`include "sysctl_defines.svh"

module sysctl_top #(
	parameter int TICKS_PER_SEC = `SYSCTL_TICKS_PER_SEC
) (
	input  logic clk,
	input  logic resetn,
	input  logic mem_valid_i,
	input  logic [`SYSCTL_ADDR_W-1:0] mem_addr_i,
	input  logic [`SYSCTL_DATA_W-1:0] mem_wdata_i,
	input  logic [`SYSCTL_STRB_W-1:0] mem_wstrb_i,
	output logic mem_ready_o,
	output logic [`SYSCTL_DATA_W-1:0] mem_rdata_o,
	output logic [`SYSCTL_SRAM_AW-1:0] sram_addr_o,
	output logic [`SYSCTL_SRAM_DW-1:0] sram_data_o,
	input  logic [`SYSCTL_SRAM_DW-1:0] sram_data_i,
	output logic sram_data_oe_o,
	output logic sram_we_n_o,
	output logic sram_oe_n_o,
	output logic sram_lb_n_o,
	output logic sram_ub_n_o,
	output logic led_o,
	output logic sd_ss_o,
	output logic sd_sck_o,
	output logic sd_mosi_o,
	input  logic sd_miso_i
);

	sysctl_target_if bram_if ();
	sysctl_target_if sram_if ();
	sysctl_target_if io_if ();

	sysctl_decoder u_decoder (
		.clk         (clk),
		.resetn      (resetn),
		.mem_valid_i (mem_valid_i),
		.mem_addr_i  (mem_addr_i),
		.mem_wdata_i (mem_wdata_i),
		.mem_wstrb_i (mem_wstrb_i),
		.mem_ready_o (mem_ready_o),
		.mem_rdata_o (mem_rdata_o),
		.bram_o      (bram_if.host),
		.sram_o      (sram_if.host),
		.io_o        (io_if.host)
	);

	sysctl_bram u_bram (
		.clk   (clk),
		.bus_i (bram_if.target)
	);

	sysctl_sram_ctrl u_sram (
		.clk            (clk),
		.resetn         (resetn),
		.bus_i          (sram_if.target),
		.sram_addr_o    (sram_addr_o),
		.sram_data_o    (sram_data_o),
		.sram_data_i    (sram_data_i),
		.sram_data_oe_o (sram_data_oe_o),
		.sram_we_n_o    (sram_we_n_o),
		.sram_oe_n_o    (sram_oe_n_o),
		.sram_lb_n_o    (sram_lb_n_o),
		.sram_ub_n_o    (sram_ub_n_o)
	);

	sysctl_io_regs #(
		.TICKS_PER_SEC (TICKS_PER_SEC)
	) u_io (
		.clk       (clk),
		.resetn    (resetn),
		.bus_i     (io_if.target),
		.led_o     (led_o),
		.sd_ss_o   (sd_ss_o),
		.sd_sck_o  (sd_sck_o),
		.sd_mosi_o (sd_mosi_o),
		.sd_miso_i (sd_miso_i)
	);

endmodule

// ==== tb_sysctl.sv ====
// Testbench for the system controller. Applies a table of bus requests to
// the top level, checks read data and pins, and models the external SRAM.
`include "sysctl_defines.svh"

module tb_sysctl;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_ENTRIES = 15;
	localparam int TICKS = 20;
	localparam int READY_BOUND = 20;
	localparam logic [31:0] SRAM_A = 32'h2000_0010;
	localparam logic [31:0] SRAM_B = 32'h2007_FFFC;

	typedef struct {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0] strb;
		logic miso;
		logic chk;
		logic [31:0] exp;
		logic pchk;
		// Pin order is led, ss, sck, mosi
		logic [3:0] pins;
	} entry_t;

	logic clk, resetn, mem_valid_i, mem_ready_o;
	logic [31:0] mem_addr_i, mem_wdata_i, mem_rdata_o;
	logic [3:0] mem_wstrb_i;
	logic [`SYSCTL_SRAM_AW-1:0] sram_addr_o;
	logic [15:0] sram_data_o, sram_data_i;
	logic sram_data_oe_o, sram_we_n_o, sram_oe_n_o, sram_lb_n_o, sram_ub_n_o;
	logic led_o, sd_ss_o, sd_sck_o, sd_mosi_o, sd_miso_i;
	logic [15:0] sram_mem [0:(1 << `SYSCTL_SRAM_AW)-1];
	entry_t tbl [NUM_ENTRIES];
	logic [31:0] sram_exp [2];
	int errors = 0;
	int checks = 0;
	int cycle_cnt = 0;

	sysctl_top #(.TICKS_PER_SEC(TICKS)) uut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	// Asynchronous SRAM, written mid-cycle while we_n is low
	// Read data only appears while oe_n is low
	assign sram_data_i = !sram_oe_n_o ? sram_mem[sram_addr_o] : 'x;
	always @(negedge clk) begin
		if (!sram_we_n_o && !sram_lb_n_o)
			sram_mem[sram_addr_o][7:0] <= sram_data_o[7:0];
		if (!sram_we_n_o && !sram_ub_n_o)
			sram_mem[sram_addr_o][15:8] <= sram_data_o[15:8];
	end

	initial begin
		repeat (NUM_ENTRIES * 10 + 200) @(posedge clk);
		$display("Watchdog expired after %0d cycles, run did not finish",
			NUM_ENTRIES * 10 + 200);
		$display("Some tests failed");
		$finish;
	end

	function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
		logic [3:0] strb);
		logic [31:0] res;
		res = old_w;
		for (int i = 0; i < 4; i++)
			if (strb[i])
				res[i*8 +: 8] = new_w[i*8 +: 8];
		return res;
	endfunction

	function automatic entry_t make_entry(logic [31:0] addr, logic [31:0] wdata,
		logic [3:0] strb, logic miso, logic chk, logic [31:0] exp, logic pchk, logic [3:0] pins);
		entry_t e;
		e = '{addr, wdata, strb, miso, chk, exp, pchk, pins};
		return e;
	endfunction

	function automatic logic [31:0] io_addr(sysctl_map_pkg::io_reg_e r);
		return `SYSCTL_IO_BASE | 32'(r);
	endfunction

	task automatic fill_table();
		logic [31:0] r [6];
		for (int i = 0; i < 6; i++)
			r[i] = $urandom;
		sram_exp[0] = merge_bytes(r[2], r[4], 4'b1100);
		sram_exp[1] = merge_bytes(r[3], r[5], 4'b0010);
		tbl[0] = make_entry(32'h0000_0100, r[0], 4'hF, 0, 0, '0, 0, '0);
		tbl[1] = make_entry(32'h0000_0100, r[1], 4'b0101, 0, 0, '0, 0, '0);
		tbl[2] = make_entry(32'h0000_0100, '0, 4'h0, 0, 1, merge_bytes(r[0], r[1], 4'b0101), 0, '0);
		tbl[3] = make_entry(SRAM_A, r[2], 4'hF, 0, 0, '0, 0, '0);
		tbl[4] = make_entry(SRAM_B, r[3], 4'hF, 0, 0, '0, 0, '0);
		tbl[5] = make_entry(SRAM_A, r[4], 4'b1100, 0, 0, '0, 0, '0);
		tbl[6] = make_entry(SRAM_B, r[5], 4'b0010, 0, 0, '0, 0, '0);
		tbl[7] = make_entry(SRAM_A, '0, 4'h0, 0, 1, sram_exp[0], 0, '0);
		tbl[8] = make_entry(SRAM_B, '0, 4'h0, 0, 1, sram_exp[1], 0, '0);
		tbl[9] = make_entry(io_addr(sysctl_map_pkg::IO_LED), 32'h1, 4'hF, 0, 0, '0, 1, 4'b0100);
		tbl[10] = make_entry(io_addr(sysctl_map_pkg::IO_LED), '0, 4'h0, 0, 1, 32'h1, 0, '0);
		tbl[11] = make_entry(io_addr(sysctl_map_pkg::IO_LED), 32'h0, 4'hF, 0, 0, '0, 1, 4'b1100);
		tbl[12] = make_entry(io_addr(sysctl_map_pkg::IO_SD), 32'hA, 4'hF, 0, 0, '0, 1, 4'b1101);
		tbl[13] = make_entry(io_addr(sysctl_map_pkg::IO_SD), '0, 4'h0, 1, 1, 32'hB, 0, '0);
		tbl[14] = make_entry(32'h5000_0000, '0, 4'h0, 0, 1, 32'h0, 0, '0);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	// One request, held until mem_ready_o is seen at a falling edge
	task automatic bus_access(input entry_t e, output logic [31:0] rdata, output int at_cycle);
		int waited;
		waited = 0;
		@(negedge clk);
		mem_valid_i = 1'b1;
		mem_addr_i = e.addr;
		mem_wdata_i = e.wdata;
		mem_wstrb_i = e.strb;
		sd_miso_i = e.miso;
		do begin
			@(negedge clk);
			waited++;
		end while (!mem_ready_o && waited < READY_BOUND);
		assert (mem_ready_o) else begin
			errors++;
			$display("No mem_ready_o within %0d cycles for address %h", READY_BOUND, e.addr);
		end
		rdata = mem_rdata_o;
		at_cycle = cycle_cnt;
		mem_valid_i = 1'b0;
		mem_wstrb_i = '0;
	endtask

	initial begin
		logic [31:0] rd, s1, s2;
		logic [`SYSCTL_SRAM_AW-1:0] idx;
		int c1, c2, exp_secs, delta;
		rd = $urandom(32'hb582d550);
		resetn = 1'b0;
		mem_valid_i = 1'b0;
		mem_addr_i = '0;
		mem_wdata_i = '0;
		mem_wstrb_i = '0;
		sd_miso_i = 1'b0;
		fill_table();
		repeat (16) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;

		for (int i = 0; i < NUM_ENTRIES; i++) begin
			bus_access(tbl[i], rd, c1);
			if (tbl[i].chk)
				check_value("mem_rdata_o", tbl[i].exp, rd);
			if (tbl[i].pchk) begin
				check_value("led_o", tbl[i].pins[3], led_o);
				check_value("sd_ss_o", tbl[i].pins[2], sd_ss_o);
				check_value("sd_sck_o", tbl[i].pins[1], sd_sck_o);
				check_value("sd_mosi_o", tbl[i].pins[0], sd_mosi_o);
			end
		end

		// Halfword index is word offset times two plus lane
		for (int k = 0; k < 2; k++) begin
			idx = {(k == 0 ? SRAM_A[`SYSCTL_SRAM_AW:2] : SRAM_B[`SYSCTL_SRAM_AW:2]), 1'b0};
			check_value("sram_mem low halfword", sram_exp[k][15:0], sram_mem[idx]);
			check_value("sram_mem high halfword", sram_exp[k][31:16], sram_mem[idx | 1'b1]);
		end

		bus_access(make_entry(io_addr(sysctl_map_pkg::IO_SECS), '0, 4'h0, 0, 0, '0, 0, '0), s1, c1);
		repeat (60) @(negedge clk);
		bus_access(make_entry(io_addr(sysctl_map_pkg::IO_SECS), '0, 4'h0, 0, 0, '0, 0, '0), s2, c2);
		exp_secs = (c2 - c1) / TICKS;
		delta = int'(s2 - s1);
		checks++;
		assert (delta >= exp_secs - 1 && delta <= exp_secs + 1) else begin
			errors++;
			$display("FAILED t=%0t mem_rdata_o seconds delta expected %0d+-1 got %0d",
				$time, exp_secs, delta);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
